/* files.f */
verilog/typedef_pkg.sv
verilog/instruction_pkg.sv
verilog/instruction_fetch.sv
verilog/instruction_decode.sv
verilog/register_file.sv
verilog/execute.sv
verilog/data_memory.sv
verilog/core_top.sv
verif/retire_checker.sv
verif/tb_core.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_core -f files.f -o tb_core &&
./obj_dir/tb_core | tee /dev/stderr | grep -qx "test passed" || exit 1

/* verif/tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import typedef_pkg::*;
();

    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_IMM    = 7'h13;
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_LUI    = 7'h37;
    localparam logic [6:0] OPC_AUIPC  = 7'h17;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam int         HALT_LIMIT = 500;

    // ADDI x24, x0, 1 placed where execution must never arrive
    localparam word_t SKIPPED = 32'h0010_0c13;

    logic      clk;
    logic      reset;
    logic      imem_we;
    addr_t     imem_addr;
    word_t     imem_wdata;
    logic      start;
    logic      retire_valid;
    addr_t     retire_pc;
    reg_addr_t retire_rd;
    logic      retire_we;
    word_t     retire_data;
    logic      halted;
    logic      illegal;
    logic      run_id;
    word_t     op_a;
    word_t     op_b;
    int        retire_errors;
    int        timeouts;
    word_t     prog [$];

    core_top #(
        .IMEM_WORDS(64),
        .DMEM_WORDS(64)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .start       (start),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_we   (retire_we),
        .retire_data (retire_data),
        .halted      (halted),
        .illegal     (illegal)
    );

    retire_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .run_id      (run_id),
        .op_a        (op_a),
        .op_b        (op_b),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_rd   (retire_rd),
        .retire_we   (retire_we),
        .retire_data (retire_data),
        .halted      (halted),
        .illegal     (illegal),
        .error_count (retire_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t i_type(input int imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    // Store word encoding only
    function automatic word_t s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t b_type(input int imm, input int rs2, input int rs1, input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t u_type(input int imm, input int rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    // Not-taken branch, taken branch over one skipped word
    task automatic add_branch_pair(input int f3, input int nt_rs1, input int nt_rs2,
                                   input int t_rs1, input int t_rs2);
        prog.push_back(b_type(8, nt_rs2, nt_rs1, f3));
        prog.push_back(b_type(8, t_rs2, t_rs1, f3));
        prog.push_back(SKIPPED);
    endtask

    task automatic build_main_program();
        prog.delete();
        prog.push_back(u_type(int'(op_a[31:12]), 1, OPC_LUI));
        prog.push_back(i_type(int'(op_a[11:0]), 1, 0, 1, OPC_IMM));
        prog.push_back(u_type(int'(op_b[31:12]), 2, OPC_LUI));
        prog.push_back(i_type(int'(op_b[11:0]), 2, 0, 2, OPC_IMM));
        prog.push_back(r_type(7'h00, 2, 1, 0, 3));
        prog.push_back(r_type(7'h20, 2, 1, 0, 4));
        prog.push_back(r_type(7'h20, 2, 1, 5, 5));
        prog.push_back(r_type(7'h00, 2, 1, 5, 6));
        prog.push_back(r_type(7'h00, 2, 1, 2, 7));
        prog.push_back(r_type(7'h00, 2, 1, 3, 8));
        prog.push_back(r_type(7'h00, 2, 1, 1, 9));
        prog.push_back(r_type(7'h00, 2, 1, 4, 10));
        prog.push_back(r_type(7'h00, 2, 1, 6, 11));
        prog.push_back(r_type(7'h00, 2, 1, 7, 12));
        prog.push_back(i_type(-1, 1, 2, 13, OPC_IMM));
        prog.push_back(i_type(-1, 2, 3, 14, OPC_IMM));
        prog.push_back(i_type(12'h404, 1, 5, 15, OPC_IMM));
        prog.push_back(i_type(-1, 1, 4, 16, OPC_IMM));
        prog.push_back(i_type(12'h0ff, 2, 7, 17, OPC_IMM));
        prog.push_back(i_type(-5, 2, 0, 19, OPC_IMM));
        prog.push_back(i_type(0, 1, 0, 0, OPC_IMM));
        prog.push_back(r_type(7'h00, 2, 0, 0, 20));
        prog.push_back(s_type(16, 1, 0));
        prog.push_back(i_type(16, 0, 2, 21, OPC_LOAD));
        prog.push_back(u_type(1, 22, OPC_AUIPC));
        prog.push_back(j_type(8, 23));
        prog.push_back(SKIPPED);
        prog.push_back(i_type(124, 0, 0, 25, OPC_IMM));
        prog.push_back(i_type(0, 25, 0, 26, OPC_JALR));
        prog.push_back(SKIPPED);
        prog.push_back(SKIPPED);
        // x1 negative, x2 positive, x20 equal to x2
        add_branch_pair(0, 1, 2, 2, 20);
        add_branch_pair(1, 2, 20, 1, 2);
        add_branch_pair(4, 2, 1, 1, 2);
        add_branch_pair(5, 1, 2, 2, 1);
        add_branch_pair(6, 1, 2, 2, 1);
        add_branch_pair(7, 2, 1, 1, 2);
        prog.push_back(32'h0000_0073);
    endtask

    task automatic build_illegal_program();
        prog.delete();
        prog.push_back(i_type(7, 0, 0, 1, OPC_IMM));
        prog.push_back(32'h0000_007f);
        prog.push_back(i_type(1, 0, 0, 2, OPC_IMM));
    endtask

    task automatic run_program(input logic which);
        int cycles;
        run_id = which;
        if (which) begin
            build_illegal_program();
        end else begin
            build_main_program();
        end
        @(posedge clk);
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= addr_t'(i * 4);
            imem_wdata <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        cycles = 0;
        while (!halted && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("Core never halted within %0d cycles in run %0d", HALT_LIMIT, which);
            timeouts++;
        end
        // Window for any retire pulse after the halt
        repeat (4) @(posedge clk);
    endtask

    initial begin
        logic  [19:0] a_hi;
        logic  [19:0] b_hi;
        logic  [10:0] a_lo;
        logic  [10:0] b_lo;
        reset      = 1'b1;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        start      = 1'b0;
        run_id     = 1'b0;
        timeouts   = 0;
        void'($urandom(47574));
        a_hi = 20'($urandom());
        a_lo = 11'($urandom());
        b_hi = 20'($urandom());
        b_lo = 11'($urandom());
        // Sign fixed so branch outcomes are known, bit 11 clear for LUI plus ADDI
        a_hi[19] = 1'b1;
        b_hi[19] = 1'b0;
        op_a = {a_hi, 1'b0, a_lo};
        op_b = {b_hi, 1'b0, b_lo};

        run_program(1'b0);
        run_program(1'b1);

        $display("Retire errors: %0d, timeouts: %0d", retire_errors, timeouts);
        if (retire_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/retire_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_checker
    import typedef_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire logic      run_id,
    input  wire word_t     op_a,
    input  wire word_t     op_b,
    input  wire logic      retire_valid,
    input  wire addr_t     retire_pc,
    input  wire reg_addr_t retire_rd,
    input  wire logic      retire_we,
    input  wire word_t     retire_data,
    input  wire logic      halted,
    input  wire logic      illegal,
    output int             error_count
);

    localparam int MAX_ENTRIES = 64;

    string     exp_name [MAX_ENTRIES];
    addr_t     exp_pc   [MAX_ENTRIES];
    reg_addr_t exp_rd   [MAX_ENTRIES];
    logic      exp_we   [MAX_ENTRIES];
    word_t     exp_data [MAX_ENTRIES];
    int        exp_count;
    int        next_index;
    logic      exp_illegal;
    logic      halt_seen;
    int        errors = 0;

    assign error_count = errors;

    task automatic add_entry(input string name, input int pc, input int rd,
                             input logic we, input word_t data);
        exp_name[exp_count] = name;
        exp_pc[exp_count]   = pc;
        exp_rd[exp_count]   = rd[4:0];
        exp_we[exp_count]   = we;
        exp_data[exp_count] = data;
        exp_count++;
    endtask

    // a is negative, b is positive, neither has bit 11 set
    task automatic build_main_expected();
        string cond [6];
        cond = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
        exp_count   = 0;
        exp_illegal = 1'b0;
        add_entry("lui x1", 0, 1, 1'b1, {op_a[31:12], 12'h000});
        add_entry("addi x1", 4, 1, 1'b1, op_a);
        add_entry("lui x2", 8, 2, 1'b1, {op_b[31:12], 12'h000});
        add_entry("addi x2", 12, 2, 1'b1, op_b);
        add_entry("add", 16, 3, 1'b1, op_a + op_b);
        add_entry("sub", 20, 4, 1'b1, op_a - op_b);
        add_entry("sra", 24, 5, 1'b1, word_t'($signed(op_a) >>> op_b[4:0]));
        add_entry("srl", 28, 6, 1'b1, op_a >> op_b[4:0]);
        // Negative below positive when signed, above when unsigned
        add_entry("slt", 32, 7, 1'b1, 32'd1);
        add_entry("sltu", 36, 8, 1'b1, 32'd0);
        add_entry("sll", 40, 9, 1'b1, op_a << op_b[4:0]);
        add_entry("xor", 44, 10, 1'b1, op_a ^ op_b);
        add_entry("or", 48, 11, 1'b1, op_a | op_b);
        add_entry("and", 52, 12, 1'b1, op_a & op_b);
        add_entry("slti", 56, 13, 1'b1, 32'd1);
        add_entry("sltiu", 60, 14, 1'b1, 32'd1);
        add_entry("srai", 64, 15, 1'b1, {{4{op_a[31]}}, op_a[31:4]});
        add_entry("xori", 68, 16, 1'b1, ~op_a);
        add_entry("andi", 72, 17, 1'b1, op_b & 32'h0000_00ff);
        add_entry("addi negative", 76, 19, 1'b1, op_b - 32'd5);
        // x0 keeps zero, the retire still shows the computed value
        add_entry("addi x0", 80, 0, 1'b1, op_a);
        add_entry("add from x0", 84, 20, 1'b1, op_b);
        add_entry("sw", 88, 0, 1'b0, '0);
        add_entry("lw", 92, 21, 1'b1, op_a);
        add_entry("auipc", 96, 22, 1'b1, 32'h0000_1060);
        add_entry("jal", 100, 23, 1'b1, 32'd104);
        add_entry("jalr base", 108, 25, 1'b1, 32'd124);
        add_entry("jalr", 112, 26, 1'b1, 32'd116);
        for (int k = 0; k < 6; k++) begin
            add_entry($sformatf("%s not taken", cond[k]), 124 + 12 * k, 0, 1'b0, '0);
            add_entry($sformatf("%s taken", cond[k]), 128 + 12 * k, 0, 1'b0, '0);
        end
        add_entry("ecall", 196, 0, 1'b0, '0);
    endtask

    task automatic build_illegal_expected();
        exp_count   = 0;
        exp_illegal = 1'b1;
        add_entry("addi before illegal", 0, 1, 1'b1, 32'd7);
        add_entry("illegal opcode", 4, 0, 1'b0, '0);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error %s: %s expected %h actual %h", name, field, expected, actual);
            errors++;
        end
    endtask

    task automatic check_retire();
        int i;
        i = next_index;
        if (halt_seen) begin
            $display("Retire pulse at pc %h after the core had halted", retire_pc);
            errors++;
        end else if (i >= exp_count) begin
            $display("Unexpected extra retire at pc %h", retire_pc);
            errors++;
        end else begin
            compare_field(exp_name[i], "pc", exp_pc[i], retire_pc);
            compare_field(exp_name[i], "rd", word_t'(exp_rd[i]), word_t'(retire_rd));
            compare_field(exp_name[i], "write enable", {31'b0, exp_we[i]}, {31'b0, retire_we});
            if (exp_we[i]) begin
                compare_field(exp_name[i], "value", exp_data[i], retire_data);
            end
            next_index++;
        end
    endtask

    // Outputs settle after the rising edge
    always @(negedge clk) begin
        if (reset) begin
            next_index = 0;
            halt_seen  = 1'b0;
            if (run_id) begin
                build_illegal_expected();
            end else begin
                build_main_expected();
            end
        end else begin
            if (retire_valid) begin
                check_retire();
            end
            // Stop instruction retires in the same cycle halted rises
            if (halted && !halt_seen) begin
                halt_seen = 1'b1;
                if (next_index != exp_count) begin
                    $display("Core halted after %0d of %0d expected retires",
                             next_index, exp_count);
                    errors++;
                end
                compare_field("halt", "illegal", {31'b0, exp_illegal}, {31'b0, illegal});
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top
    import typedef_pkg::*;
    import instruction_pkg::*;
#(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  imem_we,
    input  wire addr_t imem_addr,
    input  wire word_t imem_wdata,
    input  wire logic  start,
    output logic       retire_valid,
    output addr_t      retire_pc,
    output reg_addr_t  retire_rd,
    output logic       retire_we,
    output word_t      retire_data,
    output logic       halted,
    output logic       illegal
);

    addr_t     pc;
    addr_t     next_pc;
    word_t     instruction;
    logic      running;
    logic      stop;
    opcode_t   opcode;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    funct3_t   funct3;
    funct7_t   funct7;
    word_t     immediate;
    logic      illegal_opcode;
    logic      is_system;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     rd_data;
    logic      rd_we;
    logic      dmem_we;
    addr_t     dmem_addr;
    word_t     dmem_wdata;
    word_t     dmem_rdata;

    instruction_fetch #(
        .IMEM_WORDS(IMEM_WORDS)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .next_pc    (next_pc),
        .stop       (stop),
        .pc         (pc),
        .instruction(instruction),
        .running    (running),
        .halted     (halted)
    );

    instruction_decode u_decode (
        .instruction   (instruction),
        .opcode        (opcode),
        .rd_addr       (rd_addr),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .funct3        (funct3),
        .funct7        (funct7),
        .immediate     (immediate),
        .illegal_opcode(illegal_opcode),
        .is_system     (is_system)
    );

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr (rd_addr),
        .rd_we   (rd_we),
        .rd_data (rd_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    execute u_execute (
        .running       (running),
        .pc            (pc),
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .immediate     (immediate),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .dmem_rdata    (dmem_rdata),
        .illegal_opcode(illegal_opcode),
        .is_system     (is_system),
        .rd_data       (rd_data),
        .rd_we         (rd_we),
        .next_pc       (next_pc),
        .dmem_we       (dmem_we),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .stop          (stop)
    );

    data_memory #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_dmem (
        .clk  (clk),
        .we   (dmem_we),
        .addr (dmem_addr),
        .wdata(dmem_wdata),
        .rdata(dmem_rdata)
    );

    // Retire flags, one pulse per completed instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_we    <= 1'b0;
            illegal      <= 1'b0;
        end else begin
            retire_valid <= running;
            retire_we    <= rd_we;
            // Rises on the same edge as halted
            if (stop) begin
                illegal <= illegal_opcode;
            end
        end
    end

    // Retire payload
    always_ff @(posedge clk) begin
        if (running) begin
            retire_pc   <= pc;
            retire_rd   <= rd_addr;
            retire_data <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory
    import typedef_pkg::*;
#(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic  clk,
    input  wire logic  we,
    input  wire addr_t addr,
    input  wire word_t wdata,
    output word_t      rdata
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t              mem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_index;

    // Byte offset bits are ignored
    assign word_index = addr[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_index] <= wdata;
        end
    end

    assign rdata = mem[word_index];

endmodule

`default_nettype wire

/* verilog/execute.sv */
`timescale 1ns/1ps
`default_nettype none

module execute
    import typedef_pkg::*;
    import instruction_pkg::*;
(
    input  wire logic    running,
    input  wire addr_t   pc,
    input  wire opcode_t opcode,
    input  wire funct3_t funct3,
    input  wire funct7_t funct7,
    input  wire word_t   immediate,
    input  wire word_t   rs1_data,
    input  wire word_t   rs2_data,
    input  wire word_t   dmem_rdata,
    input  wire logic    illegal_opcode,
    input  wire logic    is_system,
    output word_t        rd_data,
    output logic         rd_we,
    output addr_t        next_pc,
    output logic         dmem_we,
    output addr_t        dmem_addr,
    output word_t        dmem_wdata,
    output logic         stop
);

    word_t      operand_b;
    logic [4:0] shamt;
    logic       alt_func;
    word_t      sra_result;
    word_t      alu_result;
    logic       taken;
    addr_t      pc_plus4;
    logic       rd_we_int;
    logic       dmem_we_int;

    assign operand_b = (opcode == OP) ? rs2_data : immediate;
    assign shamt     = operand_b[4:0];
    assign pc_plus4  = pc + 32'd4;

    // SUB and SRA flag is funct7 bit 5 for OP
    // For OP_IMM only the shift has it, as immediate bit 10
    assign alt_func = (opcode == OP) ? funct7[5]
                                     : (funct3 == F3_SRL_SRA && immediate[10]);
    assign sra_result = $signed(rs1_data) >>> shamt;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_result = alt_func ? rs1_data - operand_b : rs1_data + operand_b;
            F3_SLL:     alu_result = rs1_data << shamt;
            F3_SLT:     alu_result = {31'b0, $signed(rs1_data) < $signed(operand_b)};
            F3_SLTU:    alu_result = {31'b0, rs1_data < operand_b};
            F3_XOR:     alu_result = rs1_data ^ operand_b;
            F3_SRL_SRA: alu_result = alt_func ? sra_result : rs1_data >> shamt;
            F3_OR:      alu_result = rs1_data | operand_b;
            default:    alu_result = rs1_data & operand_b;
        endcase
    end

    // Branch condition
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (rs1_data == rs2_data);
            F3_BNE:  taken = (rs1_data != rs2_data);
            F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
            F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            F3_BLTU: taken = (rs1_data < rs2_data);
            F3_BGEU: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        rd_data     = alu_result;
        rd_we_int   = 1'b0;
        next_pc     = pc_plus4;
        dmem_we_int = 1'b0;
        case (opcode)
            OP, OP_IMM: rd_we_int = 1'b1;
            LUI: begin
                rd_data   = immediate;
                rd_we_int = 1'b1;
            end
            AUIPC: begin
                rd_data   = pc + immediate;
                rd_we_int = 1'b1;
            end
            JAL: begin
                rd_data   = pc_plus4;
                rd_we_int = 1'b1;
                next_pc   = pc + immediate;
            end
            JALR: begin
                rd_data   = pc_plus4;
                rd_we_int = 1'b1;
                next_pc   = (rs1_data + immediate) & ~32'd1;
            end
            BRANCH: begin
                if (taken) begin
                    next_pc = pc + immediate;
                end
            end
            // Size variants act as LW
            LOAD: begin
                rd_data   = dmem_rdata;
                rd_we_int = 1'b1;
            end
            STORE: dmem_we_int = 1'b1;
            default: ;
        endcase
    end

    assign dmem_addr  = rs1_data + immediate;
    assign dmem_wdata = rs2_data;

    assign rd_we   = running && rd_we_int;
    assign dmem_we = running && dmem_we_int;
    assign stop    = running && (is_system || illegal_opcode);

endmodule

`default_nettype wire

/* verilog/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file
    import typedef_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      reset,
    input  wire reg_addr_t rs1_addr,
    input  wire reg_addr_t rs2_addr,
    input  wire reg_addr_t rd_addr,
    input  wire logic      rd_we,
    input  wire word_t     rd_data,
    output word_t          rs1_data,
    output word_t          rs2_data
);

    // x1 to x31, x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // Old value is seen during a same-cycle write
    always_comb begin
        rs1_data = '0;
        rs2_data = '0;
        if (rs1_addr != '0) begin
            rs1_data = regs[rs1_addr];
        end
        if (rs2_addr != '0) begin
            rs2_data = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

/* verilog/instruction_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_decode
    import typedef_pkg::*;
    import instruction_pkg::*;
(
    input  wire word_t instruction,
    output opcode_t    opcode,
    output reg_addr_t  rd_addr,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output funct3_t    funct3,
    output funct7_t    funct7,
    output word_t      immediate,
    output logic       illegal_opcode,
    output logic       is_system
);

    assign opcode    = opcode_t'(instruction[6:0]);
    assign is_system = (opcode == SYSTEM);

    always_comb begin
        // Unused fields stay zero
        rd_addr        = '0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        funct3         = '0;
        funct7         = '0;
        immediate      = '0;
        illegal_opcode = 1'b0;

        case (opcode)
            LOAD, OP_IMM, JALR: begin
                // I-type
                immediate = {{20{instruction[31]}}, instruction[31:20]};
                rs1_addr  = instruction[19:15];
                funct3    = instruction[14:12];
                rd_addr   = instruction[11:7];
            end
            STORE: begin
                // S-type
                immediate = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
                rs2_addr  = instruction[24:20];
                rs1_addr  = instruction[19:15];
                funct3    = instruction[14:12];
            end
            OP: begin
                // R-type, no immediate
                funct7   = instruction[31:25];
                rs2_addr = instruction[24:20];
                rs1_addr = instruction[19:15];
                funct3   = instruction[14:12];
                rd_addr  = instruction[11:7];
            end
            LUI, AUIPC: begin
                // U-type, upper 20 bits in place
                immediate = {instruction[31:12], 12'h000};
                rd_addr   = instruction[11:7];
            end
            JAL: begin
                // J-type
                immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                             instruction[20], instruction[30:21], 1'b0};
                rd_addr   = instruction[11:7];
            end
            BRANCH: begin
                // B-type
                immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
                             instruction[30:25], instruction[11:8], 1'b0};
                rs2_addr  = instruction[24:20];
                rs1_addr  = instruction[19:15];
                funct3    = instruction[14:12];
            end
            SYSTEM: begin
                // ECALL and EBREAK differ only in bits 31 to 20
                immediate = {20'h00000, instruction[31:20]};
            end
            default: begin
                illegal_opcode = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/instruction_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_fetch
    import typedef_pkg::*;
    import instruction_pkg::*;
#(
    parameter int IMEM_WORDS = 64
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  start,
    input  wire logic  imem_we,
    input  wire addr_t imem_addr,
    input  wire word_t imem_wdata,
    input  wire addr_t next_pc,
    input  wire logic  stop,
    output addr_t      pc,
    output word_t      instruction,
    output logic       running,
    output logic       halted
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    core_state_t state;
    word_t       imem [IMEM_WORDS];

    // Program load, only while the core is idle
    always_ff @(posedge clk) begin
        if (imem_we && state == IDLE) begin
            imem[imem_addr[IMEM_AW+1:2]] <= imem_wdata;
        end
    end

    assign instruction = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUNNING;
                        pc    <= '0;
                    end
                end
                RUNNING: begin
                    pc <= next_pc;
                    // Stop instruction still retires this cycle
                    if (stop) begin
                        state <= HALTED;
                    end
                end
                default: begin
                    state <= HALTED;
                end
            endcase
        end
    end

    assign running = (state == RUNNING);
    assign halted  = (state == HALTED);

endmodule

`default_nettype wire

/* verilog/instruction_pkg.sv */
`default_nettype none

package instruction_pkg;

    import typedef_pkg::*;

    // Base opcodes recognised by the decoder
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        SYSTEM = 7'b1110011
    } opcode_t;

    // ALU functions for OP and OP_IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Run control of the core
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        RUNNING = 2'd1,
        HALTED  = 2'd2
    } core_state_t;

endpackage

`default_nettype wire

/* verilog/typedef_pkg.sv */
`default_nettype none

package typedef_pkg;

    // Data word, instruction word or immediate
    typedef logic [31:0] word_t;

    // Byte address for the PC and data accesses
    typedef logic [31:0] addr_t;

    // Register index, x0 to x31
    typedef logic [4:0] reg_addr_t;

    // Minor function field, instruction bits 14 to 12
    typedef logic [2:0] funct3_t;

    // Major function field, instruction bits 31 to 25
    typedef logic [6:0] funct7_t;

endpackage

`default_nettype wire
